//--- rtl/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

`define RV_RESET_PC   32'h0000_0000
`define RV_NOP        32'h0000_0013

`define RV_OP_LUI     7'b0110111
`define RV_OP_AUIPC   7'b0010111
`define RV_OP_JAL     7'b1101111
`define RV_OP_JALR    7'b1100111
`define RV_OP_BRANCH  7'b1100011
`define RV_OP_LOAD    7'b0000011
`define RV_OP_STORE   7'b0100011
`define RV_OP_OPIMM   7'b0010011
`define RV_OP_OP      7'b0110011

// funct3 of OP and OP-IMM
`define RV_F3_ADD     3'b000
`define RV_F3_SLL     3'b001
`define RV_F3_SLT     3'b010
`define RV_F3_SLTU    3'b011
`define RV_F3_XOR     3'b100
`define RV_F3_SR      3'b101
`define RV_F3_OR      3'b110
`define RV_F3_AND     3'b111

// funct3 of BRANCH
`define RV_F3_BEQ     3'b000
`define RV_F3_BNE     3'b001
`define RV_F3_BLT     3'b100
`define RV_F3_BGE     3'b101
`define RV_F3_BLTU    3'b110
`define RV_F3_BGEU    3'b111

`define RV_ALU_ADD    4'd0
`define RV_ALU_SUB    4'd1
`define RV_ALU_SLL    4'd2
`define RV_ALU_SLT    4'd3
`define RV_ALU_SLTU   4'd4
`define RV_ALU_XOR    4'd5
`define RV_ALU_SRL    4'd6
`define RV_ALU_SRA    4'd7
`define RV_ALU_OR     4'd8
`define RV_ALU_AND    4'd9
`define RV_ALU_COPY_B 4'd10

`define RV_WB_ALU     3'd0
`define RV_WB_UIMM    3'd1
`define RV_WB_PC4     3'd2
`define RV_WB_LOAD    3'd3

// low bits of the load/store funct3
`define RV_SIZE_BYTE  2'b00
`define RV_SIZE_HALF  2'b01
`define RV_SIZE_WORD  2'b10

`define RV_FWD_NONE   2'b00
`define RV_FWD_EXMEM  2'b01
`define RV_FWD_MEMWB  2'b10

`endif

//--- rtl/rv_pkg.sv
`default_nettype none

package rv_pkg;

	// data, address or instruction
	typedef logic [31:0] word_t;

	typedef logic [4:0] reg_idx_t;

	typedef logic [3:0] alu_op_t;

	// same encoding as the branch funct3
	typedef logic [2:0] cmp_op_t;

	// alu, upper immediate, pc+4 or load
	typedef logic [2:0] wb_sel_t;

	typedef logic [1:0] mem_size_t;

	// one bit per byte lane
	typedef logic [3:0] byte_en_t;

endpackage

`default_nettype wire

//--- rtl/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_defs.svh"

module fetch_stage (
	input logic clk,
	input logic rst,
	input logic load_pipeline,
	input logic stall,
	input logic flush,
	input rv_pkg::word_t target,
	input rv_pkg::word_t inst,
	output rv_pkg::word_t inst_addr,
	output rv_pkg::word_t ifid_pc,
	output rv_pkg::word_t ifid_inst,
	output logic ifid_valid
);
	import rv_pkg::*;

	word_t pc;
	word_t pc_next;

	assign inst_addr = pc;

	// taken branch or jump beats the load-use hold
	always_comb begin
		if (flush)
			pc_next = target;
		else if (stall)
			pc_next = pc;
		else
			pc_next = pc + 32'd4;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= `RV_RESET_PC;
			ifid_valid <= 1'b0;
			ifid_inst <= `RV_NOP;
		end else if (load_pipeline) begin
			pc <= pc_next;
			if (flush) begin
				ifid_valid <= 1'b0;
				ifid_inst <= `RV_NOP;
			end else if (!stall) begin
				ifid_valid <= 1'b1;
				ifid_inst <= inst;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load_pipeline && !stall)
			ifid_pc <= pc;
	end

endmodule

`default_nettype wire

//--- rtl/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_defs.svh"

module decode_stage (
	input logic clk,
	input logic rst,
	input logic load_pipeline,
	input logic stall,
	input logic flush,
	input rv_pkg::word_t ifid_pc,
	input rv_pkg::word_t ifid_inst,
	input logic ifid_valid,
	input logic wb_write,
	input rv_pkg::reg_idx_t wb_rd,
	input rv_pkg::word_t wb_data,
	output rv_pkg::reg_idx_t id_rs1,
	output rv_pkg::reg_idx_t id_rs2,
	output logic id_rs1_valid,
	output logic id_rs2_valid,
	output rv_pkg::word_t idex_pc,
	output rv_pkg::word_t idex_rs1_val,
	output rv_pkg::word_t idex_rs2_val,
	output rv_pkg::reg_idx_t idex_rs1,
	output rv_pkg::reg_idx_t idex_rs2,
	output rv_pkg::reg_idx_t idex_rd,
	output logic idex_rs1_valid,
	output logic idex_rs2_valid,
	output rv_pkg::word_t idex_imm,
	output rv_pkg::alu_op_t idex_alu_op,
	output logic idex_a_pc,
	output logic idex_b_imm,
	output logic idex_is_branch,
	output logic idex_is_jal,
	output logic idex_is_jalr,
	output rv_pkg::cmp_op_t idex_cmp_op,
	output logic idex_mem_read,
	output logic idex_mem_write,
	output rv_pkg::mem_size_t idex_mem_size,
	output logic idex_mem_unsigned,
	output rv_pkg::wb_sel_t idex_wb_sel,
	output logic idex_reg_write
);
	import rv_pkg::*;

	word_t regs [1:31];

	logic [6:0] opcode;
	logic [2:0] funct3;
	reg_idx_t rd;
	logic is_sub;
	word_t imm_i;
	word_t imm_s;
	word_t imm_b;
	word_t imm_u;
	word_t imm_j;
	word_t rs1_val;
	word_t rs2_val;
	alu_op_t f3_alu_op;
	word_t dec_imm;
	alu_op_t dec_alu_op;
	logic dec_a_pc;
	logic dec_b_imm;
	logic dec_is_branch;
	logic dec_is_jal;
	logic dec_is_jalr;
	logic dec_mem_read;
	logic dec_mem_write;
	wb_sel_t dec_wb_sel;
	logic dec_reg_write;
	logic kill;

	assign opcode = ifid_inst[6:0];
	assign rd = ifid_inst[11:7];
	assign funct3 = ifid_inst[14:12];
	assign id_rs1 = ifid_inst[19:15];
	assign id_rs2 = ifid_inst[24:20];
	assign is_sub = (opcode == `RV_OP_OP) && ifid_inst[30];

	assign imm_i = {{20{ifid_inst[31]}}, ifid_inst[31:20]};
	assign imm_s = {{20{ifid_inst[31]}}, ifid_inst[31:25], ifid_inst[11:7]};
	assign imm_b = {{19{ifid_inst[31]}}, ifid_inst[31], ifid_inst[7], ifid_inst[30:25],
		ifid_inst[11:8], 1'b0};
	assign imm_u = {ifid_inst[31:12], 12'h000};
	assign imm_j = {{11{ifid_inst[31]}}, ifid_inst[31], ifid_inst[19:12], ifid_inst[20],
		ifid_inst[30:21], 1'b0};

	// x0 reads zero, writeback bypasses the array
	assign rs1_val = (id_rs1 == '0) ? '0 :
		(wb_write && wb_rd == id_rs1) ? wb_data : regs[id_rs1];
	assign rs2_val = (id_rs2 == '0) ? '0 :
		(wb_write && wb_rd == id_rs2) ? wb_data : regs[id_rs2];

	always_ff @(posedge clk) begin
		if (load_pipeline && wb_write && wb_rd != '0)
			regs[wb_rd] <= wb_data;
	end

	always_comb begin
		case (funct3)
			`RV_F3_ADD: f3_alu_op = is_sub ? `RV_ALU_SUB : `RV_ALU_ADD;
			`RV_F3_SLL: f3_alu_op = `RV_ALU_SLL;
			`RV_F3_SLT: f3_alu_op = `RV_ALU_SLT;
			`RV_F3_SLTU: f3_alu_op = `RV_ALU_SLTU;
			`RV_F3_XOR: f3_alu_op = `RV_ALU_XOR;
			`RV_F3_SR: f3_alu_op = ifid_inst[30] ? `RV_ALU_SRA : `RV_ALU_SRL;
			`RV_F3_OR: f3_alu_op = `RV_ALU_OR;
			default: f3_alu_op = `RV_ALU_AND;
		endcase
	end

	// fence, system and unknown opcodes fall through as nops
	always_comb begin
		id_rs1_valid = 1'b0;
		id_rs2_valid = 1'b0;
		dec_reg_write = 1'b0;
		dec_mem_read = 1'b0;
		dec_mem_write = 1'b0;
		dec_is_branch = 1'b0;
		dec_is_jal = 1'b0;
		dec_is_jalr = 1'b0;
		dec_a_pc = 1'b0;
		dec_b_imm = 1'b1;
		dec_alu_op = `RV_ALU_ADD;
		dec_wb_sel = `RV_WB_ALU;
		dec_imm = imm_i;
		if (ifid_valid) begin
			case (opcode)
				`RV_OP_LUI: begin
					dec_reg_write = 1'b1;
					dec_alu_op = `RV_ALU_COPY_B;
					dec_wb_sel = `RV_WB_UIMM;
					dec_imm = imm_u;
				end
				`RV_OP_AUIPC: begin
					dec_reg_write = 1'b1;
					dec_a_pc = 1'b1;
					dec_imm = imm_u;
				end
				`RV_OP_JAL: begin
					dec_reg_write = 1'b1;
					dec_is_jal = 1'b1;
					dec_a_pc = 1'b1;
					dec_wb_sel = `RV_WB_PC4;
					dec_imm = imm_j;
				end
				`RV_OP_JALR: begin
					id_rs1_valid = 1'b1;
					dec_reg_write = 1'b1;
					dec_is_jalr = 1'b1;
					dec_wb_sel = `RV_WB_PC4;
				end
				`RV_OP_BRANCH: begin
					id_rs1_valid = 1'b1;
					id_rs2_valid = 1'b1;
					dec_is_branch = 1'b1;
					dec_a_pc = 1'b1;
					dec_imm = imm_b;
				end
				`RV_OP_LOAD: begin
					id_rs1_valid = 1'b1;
					dec_reg_write = 1'b1;
					dec_mem_read = 1'b1;
					dec_wb_sel = `RV_WB_LOAD;
				end
				`RV_OP_STORE: begin
					id_rs1_valid = 1'b1;
					id_rs2_valid = 1'b1;
					dec_mem_write = 1'b1;
					dec_imm = imm_s;
				end
				`RV_OP_OPIMM: begin
					id_rs1_valid = 1'b1;
					dec_reg_write = 1'b1;
					dec_alu_op = f3_alu_op;
				end
				`RV_OP_OP: begin
					id_rs1_valid = 1'b1;
					id_rs2_valid = 1'b1;
					dec_reg_write = 1'b1;
					dec_b_imm = 1'b0;
					dec_alu_op = f3_alu_op;
				end
				default: begin
				end
			endcase
		end
	end

	// bubble on load-use stall or redirect
	assign kill = stall || flush;

	always_ff @(posedge clk) begin
		if (rst) begin
			idex_rs1_valid <= 1'b0;
			idex_rs2_valid <= 1'b0;
			idex_reg_write <= 1'b0;
			idex_mem_read <= 1'b0;
			idex_mem_write <= 1'b0;
			idex_is_branch <= 1'b0;
			idex_is_jal <= 1'b0;
			idex_is_jalr <= 1'b0;
		end else if (load_pipeline) begin
			idex_rs1_valid <= id_rs1_valid && !kill;
			idex_rs2_valid <= id_rs2_valid && !kill;
			idex_reg_write <= dec_reg_write && !kill;
			idex_mem_read <= dec_mem_read && !kill;
			idex_mem_write <= dec_mem_write && !kill;
			idex_is_branch <= dec_is_branch && !kill;
			idex_is_jal <= dec_is_jal && !kill;
			idex_is_jalr <= dec_is_jalr && !kill;
		end
	end

	always_ff @(posedge clk) begin
		if (load_pipeline) begin
			idex_pc <= ifid_pc;
			idex_rs1_val <= rs1_val;
			idex_rs2_val <= rs2_val;
			idex_rs1 <= id_rs1;
			idex_rs2 <= id_rs2;
			idex_rd <= rd;
			idex_imm <= dec_imm;
			idex_alu_op <= dec_alu_op;
			idex_a_pc <= dec_a_pc;
			idex_b_imm <= dec_b_imm;
			idex_cmp_op <= funct3;
			idex_mem_size <= funct3[1:0];
			idex_mem_unsigned <= funct3[2];
			idex_wb_sel <= dec_wb_sel;
		end
	end

endmodule

`default_nettype wire

//--- rtl/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_defs.svh"

module hazard_unit (
	input rv_pkg::reg_idx_t id_rs1,
	input rv_pkg::reg_idx_t id_rs2,
	input logic id_rs1_valid,
	input logic id_rs2_valid,
	input rv_pkg::reg_idx_t idex_rs1,
	input rv_pkg::reg_idx_t idex_rs2,
	input logic idex_rs1_valid,
	input logic idex_rs2_valid,
	input rv_pkg::reg_idx_t idex_rd,
	input logic idex_mem_read,
	input logic idex_reg_write,
	input rv_pkg::reg_idx_t exmem_rd,
	input logic exmem_reg_write,
	input rv_pkg::reg_idx_t memwb_rd,
	input logic memwb_reg_write,
	input logic redirect,
	output logic [1:0] fwd_a,
	output logic [1:0] fwd_b,
	output logic stall,
	output logic flush
);
	import rv_pkg::*;

	// source matches a live destination other than x0
	function automatic logic hit(input reg_idx_t src, input logic src_valid,
		input reg_idx_t dst, input logic dst_write);
		return src_valid && dst_write && (dst != '0) && (dst == src);
	endfunction

	// younger result in ex/mem wins
	assign fwd_a = hit(idex_rs1, idex_rs1_valid, exmem_rd, exmem_reg_write) ? `RV_FWD_EXMEM :
		hit(idex_rs1, idex_rs1_valid, memwb_rd, memwb_reg_write) ? `RV_FWD_MEMWB :
		`RV_FWD_NONE;
	assign fwd_b = hit(idex_rs2, idex_rs2_valid, exmem_rd, exmem_reg_write) ? `RV_FWD_EXMEM :
		hit(idex_rs2, idex_rs2_valid, memwb_rd, memwb_reg_write) ? `RV_FWD_MEMWB :
		`RV_FWD_NONE;

	// load data is only ready once the load reaches writeback
	assign stall = idex_mem_read &&
		(hit(id_rs1, id_rs1_valid, idex_rd, idex_reg_write) ||
		hit(id_rs2, id_rs2_valid, idex_rd, idex_reg_write));

	assign flush = redirect;

endmodule

`default_nettype wire

//--- rtl/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_defs.svh"

module execute_stage (
	input logic clk,
	input logic rst,
	input logic load_pipeline,
	input rv_pkg::word_t idex_pc,
	input rv_pkg::word_t idex_rs1_val,
	input rv_pkg::word_t idex_rs2_val,
	input rv_pkg::reg_idx_t idex_rd,
	input rv_pkg::word_t idex_imm,
	input rv_pkg::alu_op_t idex_alu_op,
	input logic idex_a_pc,
	input logic idex_b_imm,
	input logic idex_is_branch,
	input logic idex_is_jal,
	input logic idex_is_jalr,
	input rv_pkg::cmp_op_t idex_cmp_op,
	input logic idex_mem_read,
	input logic idex_mem_write,
	input rv_pkg::mem_size_t idex_mem_size,
	input logic idex_mem_unsigned,
	input rv_pkg::wb_sel_t idex_wb_sel,
	input logic idex_reg_write,
	input logic [1:0] fwd_a,
	input logic [1:0] fwd_b,
	input rv_pkg::word_t exmem_fwd_data,
	input rv_pkg::word_t wb_data,
	output logic redirect,
	output rv_pkg::word_t target,
	output rv_pkg::word_t exmem_alu,
	output rv_pkg::word_t exmem_store_data,
	output rv_pkg::word_t exmem_pc_plus4,
	output rv_pkg::word_t exmem_uimm,
	output rv_pkg::reg_idx_t exmem_rd,
	output logic exmem_reg_write,
	output rv_pkg::wb_sel_t exmem_wb_sel,
	output logic exmem_mem_read,
	output logic exmem_mem_write,
	output rv_pkg::mem_size_t exmem_mem_size,
	output logic exmem_mem_unsigned
);
	import rv_pkg::*;

	word_t rs1_fwd;
	word_t rs2_fwd;
	word_t alu_a;
	word_t alu_b;
	word_t alu_y;
	logic taken;

	function automatic word_t fwd_pick(input logic [1:0] sel, input word_t reg_val,
		input word_t ex_val, input word_t wb_val);
		case (sel)
			`RV_FWD_EXMEM: return ex_val;
			`RV_FWD_MEMWB: return wb_val;
			default: return reg_val;
		endcase
	endfunction

	assign rs1_fwd = fwd_pick(fwd_a, idex_rs1_val, exmem_fwd_data, wb_data);
	assign rs2_fwd = fwd_pick(fwd_b, idex_rs2_val, exmem_fwd_data, wb_data);
	assign alu_a = idex_a_pc ? idex_pc : rs1_fwd;
	assign alu_b = idex_b_imm ? idex_imm : rs2_fwd;

	always_comb begin
		case (idex_alu_op)
			`RV_ALU_SUB: alu_y = alu_a - alu_b;
			`RV_ALU_SLL: alu_y = alu_a << alu_b[4:0];
			`RV_ALU_SLT: alu_y = {31'b0, $signed(alu_a) < $signed(alu_b)};
			`RV_ALU_SLTU: alu_y = {31'b0, alu_a < alu_b};
			`RV_ALU_XOR: alu_y = alu_a ^ alu_b;
			`RV_ALU_SRL: alu_y = alu_a >> alu_b[4:0];
			`RV_ALU_SRA: alu_y = word_t'($signed(alu_a) >>> alu_b[4:0]);
			`RV_ALU_OR: alu_y = alu_a | alu_b;
			`RV_ALU_AND: alu_y = alu_a & alu_b;
			`RV_ALU_COPY_B: alu_y = alu_b;
			default: alu_y = alu_a + alu_b;
		endcase
	end

	always_comb begin
		case (idex_cmp_op)
			`RV_F3_BEQ: taken = rs1_fwd == rs2_fwd;
			`RV_F3_BNE: taken = rs1_fwd != rs2_fwd;
			`RV_F3_BLT: taken = $signed(rs1_fwd) < $signed(rs2_fwd);
			`RV_F3_BGE: taken = $signed(rs1_fwd) >= $signed(rs2_fwd);
			`RV_F3_BLTU: taken = rs1_fwd < rs2_fwd;
			`RV_F3_BGEU: taken = rs1_fwd >= rs2_fwd;
			default: taken = 1'b0;
		endcase
	end

	// the alu adds pc or rs1 to the offset for every redirect
	assign redirect = (idex_is_branch && taken) || idex_is_jal || idex_is_jalr;
	assign target = {alu_y[31:1], alu_y[0] & ~idex_is_jalr};

	always_ff @(posedge clk) begin
		if (rst) begin
			exmem_reg_write <= 1'b0;
			exmem_mem_read <= 1'b0;
			exmem_mem_write <= 1'b0;
		end else if (load_pipeline) begin
			exmem_reg_write <= idex_reg_write;
			exmem_mem_read <= idex_mem_read;
			exmem_mem_write <= idex_mem_write;
		end
	end

	always_ff @(posedge clk) begin
		if (load_pipeline) begin
			exmem_alu <= alu_y;
			exmem_store_data <= rs2_fwd;
			exmem_pc_plus4 <= idex_pc + 32'd4;
			exmem_uimm <= idex_imm;
			exmem_rd <= idex_rd;
			exmem_wb_sel <= idex_wb_sel;
			exmem_mem_size <= idex_mem_size;
			exmem_mem_unsigned <= idex_mem_unsigned;
		end
	end

endmodule

`default_nettype wire

//--- rtl/memory_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_defs.svh"

module memory_stage (
	input logic clk,
	input logic rst,
	input logic load_pipeline,
	input rv_pkg::word_t exmem_alu,
	input rv_pkg::word_t exmem_store_data,
	input rv_pkg::word_t exmem_pc_plus4,
	input rv_pkg::word_t exmem_uimm,
	input rv_pkg::reg_idx_t exmem_rd,
	input logic exmem_reg_write,
	input rv_pkg::wb_sel_t exmem_wb_sel,
	input logic exmem_mem_read,
	input logic exmem_mem_write,
	input rv_pkg::mem_size_t exmem_mem_size,
	input logic exmem_mem_unsigned,
	input rv_pkg::word_t mem_rdata,
	output rv_pkg::word_t mem_address,
	output rv_pkg::word_t mem_wdata,
	output rv_pkg::byte_en_t mem_byte_enable,
	output logic dread,
	output logic dwrite,
	output rv_pkg::word_t exmem_fwd_data,
	output rv_pkg::word_t wb_data,
	output rv_pkg::reg_idx_t wb_rd,
	output logic wb_write
);
	import rv_pkg::*;

	byte_en_t size_mask;
	word_t memwb_result;
	reg_idx_t memwb_rd;
	logic memwb_reg_write;
	wb_sel_t memwb_wb_sel;
	mem_size_t memwb_mem_size;
	logic memwb_mem_unsigned;
	logic [1:0] memwb_lane;
	word_t load_shifted;
	word_t load_data;

	always_comb begin
		case (exmem_mem_size)
			`RV_SIZE_BYTE: size_mask = 4'b0001;
			`RV_SIZE_HALF: size_mask = 4'b0011;
			`RV_SIZE_WORD: size_mask = 4'b1111;
			default: size_mask = 4'b1111;
		endcase
	end

	assign mem_address = exmem_alu;
	assign mem_wdata = exmem_store_data << {exmem_alu[1:0], 3'b000};
	assign mem_byte_enable = size_mask << exmem_alu[1:0];
	// one strobe per access even when the pipeline holds
	assign dread = exmem_mem_read && load_pipeline;
	assign dwrite = exmem_mem_write && load_pipeline;

	always_comb begin
		case (exmem_wb_sel)
			`RV_WB_UIMM: exmem_fwd_data = exmem_uimm;
			`RV_WB_PC4: exmem_fwd_data = exmem_pc_plus4;
			default: exmem_fwd_data = exmem_alu;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			memwb_reg_write <= 1'b0;
		else if (load_pipeline)
			memwb_reg_write <= exmem_reg_write;
	end

	always_ff @(posedge clk) begin
		if (load_pipeline) begin
			memwb_result <= exmem_fwd_data;
			memwb_rd <= exmem_rd;
			memwb_wb_sel <= exmem_wb_sel;
			memwb_mem_size <= exmem_mem_size;
			memwb_mem_unsigned <= exmem_mem_unsigned;
			memwb_lane <= exmem_alu[1:0];
		end
	end

	// read data arrives while the load sits in writeback
	assign load_shifted = mem_rdata >> {memwb_lane, 3'b000};

	always_comb begin
		case (memwb_mem_size)
			`RV_SIZE_BYTE: load_data = memwb_mem_unsigned ? {24'b0, load_shifted[7:0]} :
				{{24{load_shifted[7]}}, load_shifted[7:0]};
			`RV_SIZE_HALF: load_data = memwb_mem_unsigned ? {16'b0, load_shifted[15:0]} :
				{{16{load_shifted[15]}}, load_shifted[15:0]};
			default: load_data = load_shifted;
		endcase
	end

	assign wb_data = (memwb_wb_sel == `RV_WB_LOAD) ? load_data : memwb_result;
	assign wb_rd = memwb_rd;
	assign wb_write = memwb_reg_write;

endmodule

`default_nettype wire

//--- rtl/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core (
	input logic clk,
	input logic rst,
	input logic load_pipeline,
	input rv_pkg::word_t inst,
	input rv_pkg::word_t mem_rdata,
	output rv_pkg::word_t inst_addr,
	output rv_pkg::word_t mem_address,
	output rv_pkg::word_t mem_wdata,
	output rv_pkg::byte_en_t mem_byte_enable,
	output logic dread,
	output logic dwrite,
	output logic stall
);
	import rv_pkg::*;

	logic flush;
	logic redirect;
	word_t target;
	logic [1:0] fwd_a;
	logic [1:0] fwd_b;

	word_t ifid_pc;
	word_t ifid_inst;
	logic ifid_valid;

	reg_idx_t id_rs1;
	reg_idx_t id_rs2;
	logic id_rs1_valid;
	logic id_rs2_valid;

	word_t idex_pc;
	word_t idex_rs1_val;
	word_t idex_rs2_val;
	reg_idx_t idex_rs1;
	reg_idx_t idex_rs2;
	reg_idx_t idex_rd;
	logic idex_rs1_valid;
	logic idex_rs2_valid;
	word_t idex_imm;
	alu_op_t idex_alu_op;
	logic idex_a_pc;
	logic idex_b_imm;
	logic idex_is_branch;
	logic idex_is_jal;
	logic idex_is_jalr;
	cmp_op_t idex_cmp_op;
	logic idex_mem_read;
	logic idex_mem_write;
	mem_size_t idex_mem_size;
	logic idex_mem_unsigned;
	wb_sel_t idex_wb_sel;
	logic idex_reg_write;

	word_t exmem_alu;
	word_t exmem_store_data;
	word_t exmem_pc_plus4;
	word_t exmem_uimm;
	reg_idx_t exmem_rd;
	logic exmem_reg_write;
	wb_sel_t exmem_wb_sel;
	logic exmem_mem_read;
	logic exmem_mem_write;
	mem_size_t exmem_mem_size;
	logic exmem_mem_unsigned;
	word_t exmem_fwd_data;

	word_t wb_data;
	reg_idx_t wb_rd;
	logic wb_write;

	fetch_stage u_fetch (.*);

	decode_stage u_decode (.*);

	// the writeback outputs are the mem/wb destination
	hazard_unit u_hazard (
		.memwb_rd(wb_rd),
		.memwb_reg_write(wb_write),
		.*
	);

	execute_stage u_execute (.*);

	memory_stage u_memory (.*);

endmodule

`default_nettype wire

//--- tb/rv_core_chk.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_chk (
	input logic clk,
	input logic rst,
	input logic load_pipeline,
	input logic dread,
	input logic dwrite,
	input rv_pkg::word_t mem_address,
	input rv_pkg::byte_en_t mem_byte_enable,
	input rv_pkg::mem_size_t exmem_mem_size
);
	import rv_pkg::*;

	// aligned mask for the access size
	function automatic logic legal_be(input mem_size_t size, input logic [1:0] lane,
		input byte_en_t be);
		case (size)
			2'b00: return be == (4'b0001 << lane);
			2'b01: return !lane[0] && be == (4'b0011 << lane);
			default: return lane == 2'b00 && be == 4'b1111;
		endcase
	endfunction

	a_quiet_after_reset: assert property (@(posedge clk) rst |=> !dread && !dwrite)
		else $error("memory strobe in the cycle after reset");

	a_one_strobe: assert property (@(posedge clk) disable iff (rst) !(dread && dwrite))
		else $error("dread and dwrite high together");

	a_byte_enable: assert property (@(posedge clk) disable iff (rst)
		(dread || dwrite) |-> legal_be(exmem_mem_size, mem_address[1:0], mem_byte_enable))
		else $error("byte enable does not fit size and address");

	a_held_no_access: assert property (@(posedge clk) disable iff (rst)
		!load_pipeline |-> !dread && !dwrite)
		else $error("memory strobe while the pipeline holds");

endmodule

`default_nettype wire

//--- tb/rv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_defs.svh"

module rv_core_tb;
	import rv_pkg::*;

	localparam int CYCLE_LIMIT = 3000;

	logic clk;
	logic rst;
	logic load_pipeline;
	word_t inst;
	word_t mem_rdata;
	word_t inst_addr;
	word_t mem_address;
	word_t mem_wdata;
	byte_en_t mem_byte_enable;
	logic dread;
	logic dwrite;
	logic stall;

	word_t imem [0:255];
	word_t dmem [0:63];
	word_t exp_addr [$];
	word_t exp_data [$];
	byte_en_t exp_be [$];
	string exp_name [$];
	int n;
	int errors;
	int stores;
	int cycles;
	logic stall_seen;
	logic [31:0] lfsr;

	rv_core u_rv_core (.*);

	assign inst = imem[inst_addr[9:2]];

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
	endfunction

	function automatic word_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
		input logic [2:0] f3, input reg_idx_t rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
		input reg_idx_t rs1, input logic [2:0] f3, input reg_idx_t rd);
		return {f7, rs2, rs1, f3, rd, `RV_OP_OP};
	endfunction

	function automatic word_t enc_s(input logic [11:0] imm, input reg_idx_t rs2,
		input reg_idx_t rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], `RV_OP_STORE};
	endfunction

	function automatic word_t enc_b(input logic [12:0] imm, input reg_idx_t rs2,
		input reg_idx_t rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OP_BRANCH};
	endfunction

	function automatic word_t enc_j(input logic [20:0] imm, input reg_idx_t rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OP_JAL};
	endfunction

	// RV32I branch conditions
	function automatic logic branch_rule(input logic [2:0] f3, input word_t a, input word_t b);
		case (f3)
			3'b000: return a == b;
			3'b001: return a != b;
			3'b100: return $signed(a) < $signed(b);
			3'b101: return $signed(a) >= $signed(b);
			3'b110: return a < b;
			default: return a >= b;
		endcase
	endfunction

	task automatic put(input word_t w);
		imem[n] = w;
		n++;
	endtask

	task automatic expect_store(input logic [2:0] f3, input reg_idx_t rs2,
		input logic [11:0] addr, input string name, input word_t value);
		byte_en_t mask;
		byte_en_t be;
		mask = (f3 == 3'b000) ? 4'b0001 : (f3 == 3'b001) ? 4'b0011 : 4'b1111;
		be = mask << addr[1:0];
		put(enc_s(addr, rs2, 5'd0, f3));
		exp_addr.push_back({20'h0, addr});
		exp_data.push_back((value << (8 * addr[1:0])) & lane_bits(be));
		exp_be.push_back(be);
		exp_name.push_back(name);
	endtask

	task automatic build_program();
		word_t a1, a2, a3, a4, a5, a6, a7, a8, a9, a10, a11, a12, a13, v, p;
		logic [2:0] f3s [6];
		int k;
		f3s = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
		// each alu step feeds the next
		a1 = 32'h123;
		a2 = a1 - 32'h45;
		a3 = a2 - a1;
		a4 = a3 << 4;
		a5 = word_t'($signed(a4) >>> 2);
		a6 = a4 >> 8;
		a7 = {31'b0, $signed(a5) < $signed(a6)};
		a8 = {31'b0, a5 < a6};
		a9 = a6 ^ 32'h55;
		a10 = a9 | a7;
		a11 = a10 & a5;
		a12 = a11 + a3;
		a13 = a12 << a7[4:0];
		put(enc_i(12'h123, 5'd0, 3'b000, 5'd1, `RV_OP_OPIMM));
		put(enc_i(-12'sh45, 5'd1, 3'b000, 5'd2, `RV_OP_OPIMM));
		put(enc_r(7'h20, 5'd1, 5'd2, 3'b000, 5'd3));
		put(enc_i(12'd4, 5'd3, 3'b001, 5'd4, `RV_OP_OPIMM));
		put(enc_i(12'h402, 5'd4, 3'b101, 5'd5, `RV_OP_OPIMM));
		put(enc_i(12'd8, 5'd4, 3'b101, 5'd6, `RV_OP_OPIMM));
		put(enc_r(7'h00, 5'd6, 5'd5, 3'b010, 5'd7));
		put(enc_r(7'h00, 5'd6, 5'd5, 3'b011, 5'd8));
		put(enc_i(12'h055, 5'd6, 3'b100, 5'd9, `RV_OP_OPIMM));
		put(enc_r(7'h00, 5'd7, 5'd9, 3'b110, 5'd10));
		put(enc_r(7'h00, 5'd5, 5'd10, 3'b111, 5'd11));
		put(enc_r(7'h00, 5'd3, 5'd11, 3'b000, 5'd12));
		put(enc_r(7'h00, 5'd7, 5'd12, 3'b001, 5'd13));
		expect_store(3'b010, 5'd13, 12'd28, "alu_sll", a13);
		expect_store(3'b010, 5'd3, 12'd0, "alu_sub", a3);
		expect_store(3'b010, 5'd5, 12'd4, "alu_srai", a5);
		expect_store(3'b010, 5'd6, 12'd8, "alu_srli", a6);
		expect_store(3'b010, 5'd7, 12'd12, "alu_slt", a7);
		expect_store(3'b010, 5'd8, 12'd16, "alu_sltu", a8);
		expect_store(3'b010, 5'd11, 12'd20, "alu_and", a11);
		expect_store(3'b010, 5'd12, 12'd24, "alu_add", a12);
		expect_store(3'b010, 5'd10, 12'd32, "alu_or", a10);
		// the addi waits one cycle for the load
		put(enc_i(12'd0, 5'd0, 3'b010, 5'd14, `RV_OP_LOAD));
		put(enc_i(12'd7, 5'd14, 3'b000, 5'd15, `RV_OP_OPIMM));
		expect_store(3'b010, 5'd15, 12'd36, "load_use", a3 + 32'd7);
		// branches skip two shadow stores when taken
		put(enc_i(-12'sd5, 5'd0, 3'b000, 5'd1, `RV_OP_OPIMM));
		put(enc_i(12'd3, 5'd0, 3'b000, 5'd2, `RV_OP_OPIMM));
		for (k = 0; k < 6; k++) begin
			put(enc_b(13'd12, 5'd2, 5'd1, f3s[k]));
			if (branch_rule(f3s[k], -32'sd5, 32'd3)) begin
				put(enc_s(12'd64 + 12'(8 * k), 5'd2, 5'd0, 3'b010));
				put(enc_s(12'd68 + 12'(8 * k), 5'd1, 5'd0, 3'b010));
			end else begin
				expect_store(3'b010, 5'd2, 12'd64 + 12'(8 * k), "branch_fall", 32'd3);
				expect_store(3'b010, 5'd1, 12'd68 + 12'(8 * k), "branch_fall", -32'sd5);
			end
			expect_store(3'b010, 5'd2, 12'd112, "branch_join", 32'd3);
		end
		// jal over one store
		p = 4 * n;
		put(enc_j(21'd8, 5'd16));
		put(enc_s(12'd124, 5'd16, 5'd0, 3'b010));
		expect_store(3'b010, 5'd16, 12'd120, "jal_link", p + 32'd4);
		// jalr with an odd offset lands on an even address
		p = 4 * n;
		put({20'h0, 5'd17, `RV_OP_AUIPC});
		put(enc_i(12'd13, 5'd17, 3'b000, 5'd18, `RV_OP_JALR));
		put(enc_s(12'd124, 5'd18, 5'd0, 3'b010));
		expect_store(3'b010, 5'd17, 12'd128, "auipc", p);
		expect_store(3'b010, 5'd18, 12'd132, "jalr_link", p + 32'd8);
		put({20'hABCDE, 5'd19, `RV_OP_LUI});
		expect_store(3'b010, 5'd19, 12'd136, "lui", 32'hABCD_E000);
		p = 4 * n;
		put({20'h00001, 5'd20, `RV_OP_AUIPC});
		expect_store(3'b010, 5'd20, 12'd140, "auipc_imm", p + 32'h1000);
		// sub-word stores to every lane, then extending loads
		v = 32'h8899_B000 + {{20{1'b1}}, 12'hABB};
		put({20'h8899B, 5'd21, `RV_OP_LUI});
		put(enc_i(12'hABB, 5'd21, 3'b000, 5'd21, `RV_OP_OPIMM));
		for (k = 0; k < 4; k++)
			expect_store(3'b000, 5'd21, 12'd160 + 12'(k), "sb_lane", v);
		expect_store(3'b001, 5'd21, 12'd164, "sh_low", v);
		expect_store(3'b001, 5'd21, 12'd166, "sh_high", v);
		put(enc_i(12'd161, 5'd0, 3'b000, 5'd22, `RV_OP_LOAD));
		put(enc_i(12'd162, 5'd0, 3'b100, 5'd23, `RV_OP_LOAD));
		put(enc_i(12'd166, 5'd0, 3'b001, 5'd24, `RV_OP_LOAD));
		put(enc_i(12'd164, 5'd0, 3'b101, 5'd25, `RV_OP_LOAD));
		expect_store(3'b010, 5'd22, 12'd168, "lb", {{24{v[7]}}, v[7:0]});
		expect_store(3'b010, 5'd23, 12'd172, "lbu", {24'b0, v[7:0]});
		expect_store(3'b010, 5'd24, 12'd176, "lh", {{16{v[15]}}, v[15:0]});
		expect_store(3'b010, 5'd25, 12'd180, "lhu", {16'b0, v[15:0]});
		put(enc_j(21'd0, 5'd0));
	endtask

	// lane mask widened to bits
	function automatic word_t lane_bits(input byte_en_t be);
		return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
	endfunction

	always @(posedge clk) begin
		int i;
		if (dwrite)
			for (i = 0; i < 4; i++)
				if (mem_byte_enable[i])
					dmem[mem_address[7:2]][8*i +: 8] <= mem_wdata[8*i +: 8];
		if (dread)
			mem_rdata <= dmem[mem_address[7:2]];
	end

	// two lfsr bits per cycle and advance unless both are zero
	always @(posedge clk) begin
		logic b0;
		logic b1;
		b0 = lfsr[0];
		lfsr = lfsr_step(lfsr);
		b1 = lfsr[0];
		lfsr = lfsr_step(lfsr);
		load_pipeline <= rst ? 1'b1 : (b0 | b1);
	end

	always @(posedge clk) begin
		if (!rst && stall)
			stall_seen <= 1'b1;
		if (!rst && dwrite) begin
			assert (exp_addr.size() != 0) else begin
				$display("store to %h issued after the last expected store", mem_address);
				errors++;
			end
			if (exp_addr.size() != 0) begin
				assert (mem_address == exp_addr[0] && mem_byte_enable == exp_be[0] &&
					(mem_wdata & lane_bits(exp_be[0])) == exp_data[0]) else begin
					$display("FAIL %s expected %h/%h/%b actual %h/%h/%b", exp_name[0],
						exp_addr[0], exp_data[0], exp_be[0], mem_address,
						mem_wdata & lane_bits(mem_byte_enable), mem_byte_enable);
					errors++;
				end
				void'(exp_addr.pop_front());
				void'(exp_data.pop_front());
				void'(exp_be.pop_front());
				void'(exp_name.pop_front());
				stores++;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, %0d stores still pending", cycles,
				exp_addr.size());
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	initial begin
		int i;
		rst = 1'b1;
		load_pipeline = 1'b1;
		mem_rdata = '0;
		lfsr = 32'h4a24_5a52;
		n = 0;
		errors = 0;
		stores = 0;
		cycles = 0;
		stall_seen = 1'b0;
		for (i = 0; i < 256; i++)
			imem[i] = `RV_NOP;
		for (i = 0; i < 64; i++)
			dmem[i] = '0;
		build_program();
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		while (inst_addr != 32'(4 * (n - 1)))
			@(posedge clk);
		// the self-jump has executed once fetch comes back to it
		while (inst_addr == 32'(4 * (n - 1)))
			@(posedge clk);
		while (inst_addr != 32'(4 * (n - 1)))
			@(posedge clk);
		@(posedge clk);
		assert (exp_addr.size() == 0) else begin
			$display("%0d expected stores were never issued", exp_addr.size());
			errors++;
		end
		assert (stall_seen) else begin
			$display("load-use stall was never raised");
			errors++;
		end
		$display("stores checked %0d, errors %0d", stores, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

bind rv_core rv_core_chk u_chk (.*);

`default_nettype wire

//--- all.f
+incdir+rtl
rtl/rv_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/hazard_unit.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/rv_core.sv
tb/rv_core_chk.sv
tb/rv_core_tb.sv

//--- Makefile
SRCS := $(wildcard rtl/*.sv rtl/*.svh tb/*.sv)

.PHONY: all run clean

all: run

obj_dir/sim: $(SRCS) all.f
	verilator --binary --assert --timing -Wno-fatal -f all.f --top-module rv_core_tb -Mdir obj_dir -o sim

run: obj_dir/sim
	./obj_dir/sim | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
